/* hw/eth_dma_consts.svh */
`ifndef ETH_DMA_CONSTS_SVH
`define ETH_DMA_CONSTS_SVH

// data path
`define ETH_DMA_DW      32
`define ETH_CMDQ_DEPTH  4

// buffer sizing, level width must hold ETH_BUF_DEPTH
`define ETH_BUF_DEPTH   64
`define ETH_BUF_LW      7

`define ETH_WR_MARK     16   // words before memory may pull
`define ETH_RD_LIMIT    48   // tx buffer words, rd_data_ready drops above
`define ETH_PLOAD_LEN   64   // max frame payload in bytes

`endif

/* hw/eth_dma_pkg.sv */
`default_nettype none

`include "eth_dma_consts.svh"

package eth_dma_pkg;

	////////////////////////////////////////////////////////////////////////
	// vector types

	typedef logic [`ETH_DMA_DW-1:0] addr_t;   // byte address
	typedef logic [`ETH_DMA_DW-1:0] len_t;    // byte length
	typedef logic [`ETH_DMA_DW-1:0] word_t;
	typedef logic [`ETH_BUF_LW-1:0] level_t;  // fifo fill level

	////////////////////////////////////////////////////////////////////////
	// command as queued by the packet front end

	typedef struct packed {
		logic  rd;    // 1 = memory to ethernet
		addr_t addr;
		len_t  len;
	} cmd_t;

	////////////////////////////////////////////////////////////////////////
	// state machines

	typedef enum logic [1:0] {
		CMD_IDLE,
		CMD_REQ,
		CMD_ACK_LOW,
		CMD_DONE_WAIT
	} cmd_state_e;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_FILL,
		TX_START,
		TX_WAIT_DONE
	} tx_state_e;

endpackage

`default_nettype wire

/* hw/eth_dma_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module eth_dma_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 64
) (
	input  wire                  i_clk,
	input  wire                  i_rstn,
	input  wire                  i_push,
	input  wire [WIDTH-1:0]      i_din,
	input  wire                  i_pop,
	output logic [WIDTH-1:0]     o_dout,
	output logic                 o_empty,
	output logic                 o_full,
	output eth_dma_pkg::level_t  o_level
);
	import eth_dma_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	level_t           count;
	logic             do_push;
	logic             do_pop;

	assign do_push = i_push && !o_full;   // overflow dropped
	assign do_pop  = i_pop && !o_empty;

	always_ff @(posedge i_clk) begin
		if (do_push) begin
			mem[wr_ptr] <= i_din;
		end
	end

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // both or neither
			endcase
		end
	end

	// head word visible without a pop
	assign o_dout  = mem[rd_ptr];
	assign o_empty = (count == '0);
	assign o_full  = (count == level_t'(DEPTH));
	assign o_level = count;

endmodule

`default_nettype wire

/* hw/eth_dma_rx_path.sv */
`timescale 1ns/1ns
`default_nettype none

`include "eth_dma_consts.svh"

module eth_dma_rx_path (
	input  wire                  dma_clk,
	input  wire                  dma_rstn,
	input  wire                  i_start,
	input  wire eth_dma_pkg::len_t   i_len,
	input  wire                  i_rx_valid,
	input  wire eth_dma_pkg::level_t i_wr_level,
	input  wire                  i_wr_done,
	output logic                 o_push,
	output logic                 o_wr_data_ready
);
	import eth_dma_pkg::*;

	logic rx_open;     // receive window armed
	len_t byte_cnt;
	len_t byte_next;
	logic rx_close;
	logic rx_all;      // whole command buffered
	logic level_hit;

	assign o_push    = rx_open && i_rx_valid;
	assign byte_next = byte_cnt + len_t'(`ETH_DMA_DW / 8);
	assign rx_close  = o_push && (byte_next >= i_len);
	assign level_hit = (i_wr_level >= level_t'(`ETH_WR_MARK));

	always_ff @(posedge dma_clk or negedge dma_rstn) begin
		if (!dma_rstn) begin
			rx_open  <= 1'b0;
			byte_cnt <= '0;
			rx_all   <= 1'b0;
		end else begin
			if (i_start) begin
				rx_open  <= 1'b1;
				byte_cnt <= '0;
			end else if (o_push) begin
				rx_open  <= !rx_close;
				byte_cnt <= byte_next;
			end

			if (i_wr_done)
				rx_all <= 1'b0;
			else if (rx_close)
				rx_all <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// memory may pull at the watermark or once the tail is in

	always_ff @(posedge dma_clk or negedge dma_rstn) begin
		if (!dma_rstn)
			o_wr_data_ready <= 1'b0;
		else
			o_wr_data_ready <= level_hit || rx_close || (rx_all && !i_wr_done);
	end

endmodule

`default_nettype wire

/* hw/eth_dma_cmd_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module eth_dma_cmd_fsm (
	input  wire                  dma_clk,
	input  wire                  dma_rstn,
	input  wire                  i_q_empty,
	input  wire eth_dma_pkg::cmd_t i_q_head,
	output logic                 o_q_pop,
	output eth_dma_pkg::cmd_t    o_cmd,
	output logic                 o_wr_req,
	input  wire                  i_wr_ack,
	input  wire                  i_wr_done,
	output logic                 o_rd_req,
	input  wire                  i_rd_ack,
	input  wire                  i_rd_done,
	output logic                 o_rx_start,
	output logic                 o_split_start
);
	import eth_dma_pkg::*;

	cmd_state_e state;
	cmd_t       cmd_q;     // active command, held until done
	logic       req_q;
	logic       ack;
	logic       done;

	// channel select by direction
	assign ack  = cmd_q.rd ? i_rd_ack : i_wr_ack;
	assign done = cmd_q.rd ? i_rd_done : i_wr_done;

	assign o_cmd    = cmd_q;
	assign o_wr_req = req_q && !cmd_q.rd;
	assign o_rd_req = req_q && cmd_q.rd;

	always_ff @(posedge dma_clk) begin
		if (state == CMD_IDLE && !i_q_empty) begin
			cmd_q <= i_q_head;   // fwft head, popped next cycle
		end
	end

	////////////////////////////////////////////////////////////////////////
	// four-phase handshake toward the memory engine

	always_ff @(posedge dma_clk or negedge dma_rstn) begin
		if (!dma_rstn) begin
			state         <= CMD_IDLE;
			req_q         <= 1'b0;
			o_q_pop       <= 1'b0;
			o_rx_start    <= 1'b0;
			o_split_start <= 1'b0;
		end else begin
			o_q_pop       <= 1'b0;
			o_rx_start    <= 1'b0;
			o_split_start <= 1'b0;
			case (state)
				CMD_IDLE: begin
					if (!i_q_empty) begin
						o_q_pop       <= 1'b1;
						o_rx_start    <= !i_q_head.rd;
						o_split_start <= i_q_head.rd;
						state         <= CMD_REQ;
					end
				end
				CMD_REQ: begin
					if (req_q && ack) begin
						req_q <= 1'b0;
						state <= CMD_ACK_LOW;
					end else begin
						req_q <= 1'b1;   // rises the cycle after pop
					end
				end
				CMD_ACK_LOW: begin
					if (!ack)
						state <= CMD_DONE_WAIT;
				end
				CMD_DONE_WAIT: begin
					if (done)
						state <= CMD_IDLE;
				end
				default: state <= CMD_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/eth_tx_len_split.sv */
`timescale 1ns/1ns
`default_nettype none

`include "eth_dma_consts.svh"

module eth_tx_len_split (
	input  wire                  dma_clk,
	input  wire                  dma_rstn,
	input  wire                  i_start,
	input  wire eth_dma_pkg::len_t   i_len,
	output logic                 o_chunk_valid,
	output eth_dma_pkg::len_t    o_chunk_len,
	input  wire                  i_permit
);
	import eth_dma_pkg::*;

	len_t remain;       // bytes not yet handed out, current chunk included
	len_t remain_next;

	function automatic len_t chunk_of(input len_t bytes);
		len_t pload;
		pload = len_t'(`ETH_PLOAD_LEN);
		return (bytes > pload) ? pload : bytes;
	endfunction

	assign remain_next = remain - o_chunk_len;

	////////////////////////////////////////////////////////////////////////
	// one chunk on offer at a time, next one after each permit

	always_ff @(posedge dma_clk or negedge dma_rstn) begin
		if (!dma_rstn) begin
			remain        <= '0;
			o_chunk_valid <= 1'b0;
			o_chunk_len   <= '0;
		end else begin
			if (i_start) begin
				remain        <= i_len;
				o_chunk_valid <= (i_len != '0);
				o_chunk_len   <= chunk_of(i_len);
			end else if (i_permit && o_chunk_valid) begin
				remain        <= remain_next;
				o_chunk_valid <= (remain_next != '0);   // last chunk consumed
				o_chunk_len   <= chunk_of(remain_next);
			end
		end
	end

endmodule

`default_nettype wire

/* hw/eth_dma_tx_seq.sv */
`timescale 1ns/1ns
`default_nettype none

`include "eth_dma_consts.svh"

module eth_dma_tx_seq (
	input  wire                  dma_clk,
	input  wire                  dma_rstn,
	input  wire                  i_chunk_valid,
	input  wire eth_dma_pkg::len_t   i_chunk_len,
	input  wire eth_dma_pkg::level_t i_tx_level,
	output logic                 o_permit,
	output logic                 o_tx_start,
	output eth_dma_pkg::len_t    o_tx_len,
	input  wire                  i_tx_done,
	output logic                 o_rd_data_ready
);
	import eth_dma_pkg::*;

	tx_state_e state;
	len_t      avail_bytes;
	logic      fill_hit;

	assign avail_bytes = len_t'(i_tx_level) * len_t'(`ETH_DMA_DW / 8);
	assign fill_hit    = (state == TX_FILL) && (avail_bytes >= i_chunk_len);

	// memory pauses while the tx buffer sits above the limit
	assign o_rd_data_ready = (i_tx_level <= level_t'(`ETH_RD_LIMIT));

	always_ff @(posedge dma_clk) begin
		if (fill_hit) begin
			o_tx_len <= i_chunk_len;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// frame sequencing

	always_ff @(posedge dma_clk or negedge dma_rstn) begin
		if (!dma_rstn) begin
			state      <= TX_IDLE;
			o_tx_start <= 1'b0;
			o_permit   <= 1'b0;
		end else begin
			o_tx_start <= 1'b0;
			o_permit   <= 1'b0;
			case (state)
				TX_IDLE: begin
					if (i_chunk_valid)
						state <= TX_FILL;
				end
				TX_FILL: begin
					if (fill_hit) begin
						o_tx_start <= 1'b1;
						state      <= TX_START;
					end
				end
				TX_START: begin
					o_permit <= 1'b1;   // splitter consumes the chunk
					state    <= i_tx_done ? TX_IDLE : TX_WAIT_DONE;
				end
				TX_WAIT_DONE: begin
					if (i_tx_done)
						state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/eth_dma_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "eth_dma_consts.svh"

module eth_dma_top (
	input  wire                  dma_clk,
	input  wire                  dma_rstn,
	// command push
	input  wire                  i_cmd_valid,
	input  wire eth_dma_pkg::cmd_t i_cmd,
	// receive stream
	input  wire                  i_rx_valid,
	input  wire eth_dma_pkg::word_t i_rx_data,
	// memory write channel
	output logic                 o_wr_req,
	input  wire                  i_wr_ack,
	output eth_dma_pkg::addr_t   o_wr_addr,
	output eth_dma_pkg::len_t    o_wr_len,
	input  wire                  i_wr_data_req,
	output eth_dma_pkg::word_t   o_wr_data,
	output logic                 o_wr_data_ready,
	input  wire                  i_wr_done,
	// memory read channel
	output logic                 o_rd_req,
	input  wire                  i_rd_ack,
	output eth_dma_pkg::addr_t   o_rd_addr,
	output eth_dma_pkg::len_t    o_rd_len,
	input  wire                  i_rd_data_valid,
	input  wire eth_dma_pkg::word_t i_rd_data,
	output logic                 o_rd_data_ready,
	input  wire                  i_rd_done,
	// mac side
	input  wire                  i_tx_data_req,
	output eth_dma_pkg::word_t   o_tx_data,
	output logic                 o_tx_start,
	output eth_dma_pkg::len_t    o_tx_len,
	input  wire                  i_tx_done
);
	import eth_dma_pkg::*;

	cmd_t   q_head;
	logic   q_empty;
	logic   q_pop;
	cmd_t   active_cmd;
	logic   rx_start;
	logic   rx_push;
	level_t wr_level;
	level_t tx_level;
	logic   split_start;
	logic   chunk_valid;
	len_t   chunk_len;
	logic   permit;

	// both channels see the active command
	assign o_wr_addr = active_cmd.addr;
	assign o_wr_len  = active_cmd.len;
	assign o_rd_addr = active_cmd.addr;
	assign o_rd_len  = active_cmd.len;

	////////////////////////////////////////////////////////////////////////
	// command queue and data buffers

	eth_dma_fifo #(.WIDTH($bits(cmd_t)), .DEPTH(`ETH_CMDQ_DEPTH)) u_cmd_q (
		.i_clk   (dma_clk),
		.i_rstn  (dma_rstn),
		.i_push  (i_cmd_valid),
		.i_din   (i_cmd),
		.i_pop   (q_pop),
		.o_dout  (q_head),
		.o_empty (q_empty),
		.o_full  (),
		.o_level ()
	);

	eth_dma_fifo #(.WIDTH(`ETH_DMA_DW), .DEPTH(`ETH_BUF_DEPTH)) u_wr_buf (
		.i_clk   (dma_clk),
		.i_rstn  (dma_rstn),
		.i_push  (rx_push),
		.i_din   (i_rx_data),
		.i_pop   (i_wr_data_req),
		.o_dout  (o_wr_data),
		.o_empty (),
		.o_full  (),
		.o_level (wr_level)
	);

	eth_dma_fifo #(.WIDTH(`ETH_DMA_DW), .DEPTH(`ETH_BUF_DEPTH)) u_tx_buf (
		.i_clk   (dma_clk),
		.i_rstn  (dma_rstn),
		.i_push  (i_rd_data_valid),
		.i_din   (i_rd_data),
		.i_pop   (i_tx_data_req),
		.o_dout  (o_tx_data),
		.o_empty (),
		.o_full  (),
		.o_level (tx_level)
	);

	////////////////////////////////////////////////////////////////////////
	// control

	eth_dma_rx_path u_rx_path (
		.dma_clk         (dma_clk),
		.dma_rstn        (dma_rstn),
		.i_start         (rx_start),
		.i_len           (active_cmd.len),
		.i_rx_valid      (i_rx_valid),
		.i_wr_level      (wr_level),
		.i_wr_done       (i_wr_done),
		.o_push          (rx_push),
		.o_wr_data_ready (o_wr_data_ready)
	);

	eth_dma_cmd_fsm u_cmd_fsm (
		.dma_clk       (dma_clk),
		.dma_rstn      (dma_rstn),
		.i_q_empty     (q_empty),
		.i_q_head      (q_head),
		.o_q_pop       (q_pop),
		.o_cmd         (active_cmd),
		.o_wr_req      (o_wr_req),
		.i_wr_ack      (i_wr_ack),
		.i_wr_done     (i_wr_done),
		.o_rd_req      (o_rd_req),
		.i_rd_ack      (i_rd_ack),
		.i_rd_done     (i_rd_done),
		.o_rx_start    (rx_start),
		.o_split_start (split_start)
	);

	eth_tx_len_split u_len_split (
		.dma_clk       (dma_clk),
		.dma_rstn      (dma_rstn),
		.i_start       (split_start),
		.i_len         (active_cmd.len),
		.o_chunk_valid (chunk_valid),
		.o_chunk_len   (chunk_len),
		.i_permit      (permit)
	);

	eth_dma_tx_seq u_tx_seq (
		.dma_clk         (dma_clk),
		.dma_rstn        (dma_rstn),
		.i_chunk_valid   (chunk_valid),
		.i_chunk_len     (chunk_len),
		.i_tx_level      (tx_level),
		.o_permit        (permit),
		.o_tx_start      (o_tx_start),
		.o_tx_len        (o_tx_len),
		.i_tx_done       (i_tx_done),
		.o_rd_data_ready (o_rd_data_ready)
	);

endmodule

`default_nettype wire

/* tests/eth_dma_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module eth_dma_sva (
	input wire i_clk,
	input wire i_rstn,
	input wire i_wr_req,
	input wire i_wr_ack,
	input wire i_rd_req,
	input wire i_rd_ack,
	input wire i_tx_start
);

	int unsigned fail_cnt = 0;   // failed assertions so far

	// req holds until ack
	wr_req_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
		(i_wr_req && !i_wr_ack) |=> i_wr_req)
		else begin
			$error("wr req dropped before ack");
			fail_cnt++;
		end

	rd_req_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
		(i_rd_req && !i_rd_ack) |=> i_rd_req)
		else begin
			$error("rd req dropped before ack");
			fail_cnt++;
		end

	// previous handshake must be fully closed
	wr_req_rise: assert property (@(posedge i_clk) disable iff (!i_rstn)
		$rose(i_wr_req) |-> !i_wr_ack)
		else begin
			$error("wr req rose with ack high");
			fail_cnt++;
		end

	rd_req_rise: assert property (@(posedge i_clk) disable iff (!i_rstn)
		$rose(i_rd_req) |-> !i_rd_ack)
		else begin
			$error("rd req rose with ack high");
			fail_cnt++;
		end

	tx_start_pulse: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_tx_start |=> !i_tx_start)
		else begin
			$error("tx start longer than one cycle");
			fail_cnt++;
		end

endmodule

bind eth_dma_cmd_fsm eth_dma_sva u_sva_cmd (
	.i_clk      (dma_clk),
	.i_rstn     (dma_rstn),
	.i_wr_req   (o_wr_req),
	.i_wr_ack   (i_wr_ack),
	.i_rd_req   (o_rd_req),
	.i_rd_ack   (i_rd_ack),
	.i_tx_start (1'b0)
);

bind eth_dma_tx_seq eth_dma_sva u_sva_tx (
	.i_clk      (dma_clk),
	.i_rstn     (dma_rstn),
	.i_wr_req   (1'b0),
	.i_wr_ack   (1'b0),
	.i_rd_req   (1'b0),
	.i_rd_ack   (1'b0),
	.i_tx_start (o_tx_start)
);

`default_nettype wire

/* tests/tb_eth_dma.sv */
`timescale 1ns/1ns
`default_nettype none

`include "eth_dma_consts.svh"

module tb_eth_dma;
	import eth_dma_pkg::*;

	localparam int N_ROWS    = 8;
	localparam int MEM_WORDS = 512;

	typedef struct packed {
		cmd_t cmd;
		logic [3:0] frames;   // expected tx frames, zero for writes
	} row_t;

	logic dma_clk, dma_rstn;
	logic i_cmd_valid, i_rx_valid, i_wr_ack, i_wr_data_req, i_wr_done;
	logic i_rd_ack, i_rd_data_valid, i_rd_done, i_tx_data_req, i_tx_done;
	cmd_t  i_cmd;
	word_t i_rx_data, i_rd_data, o_wr_data, o_tx_data;
	logic  o_wr_req, o_wr_data_ready, o_rd_req, o_rd_data_ready, o_tx_start;
	addr_t o_wr_addr, o_rd_addr;
	len_t  o_wr_len, o_rd_len, o_tx_len;

	row_t   tbl [N_ROWS];
	word_t  mem [MEM_WORDS];
	word_t  exp_wr[$];      // rx stream, in order
	word_t  exp_tx[$];      // memory words streamed for reads
	len_t   exp_chunk[$];
	integer seed = 10932;
	int     cmds_done = 0;
	int     frames_done = 0;
	int     frames_target = 0;
	int     tx_words = 0;   // tx buffer fill seen from the ports
	int     cycles = 0;
	int     limit = 0;

	eth_dma_top UUT (.*);

	initial begin
		dma_clk = 1'b0;
		forever #4 dma_clk = ~dma_clk;
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks

	task automatic stop_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_len(input string name, input len_t got, input len_t exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	function automatic len_t chunk_len_of(input len_t len, input int k);
		len_t rest;
		rest = len - len_t'(k * `ETH_PLOAD_LEN);
		return (rest > `ETH_PLOAD_LEN) ? len_t'(`ETH_PLOAD_LEN) : rest;
	endfunction

	always @(posedge dma_clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: commands did not complete within %0d cycles", limit);
			stop_run();
		end
	end

	// a failed bound assertion ends the run
	always @(negedge dma_clk) begin
		if (UUT.u_cmd_fsm.u_sva_cmd.fail_cnt != 0 ||
				UUT.u_tx_seq.u_sva_tx.fail_cnt != 0) begin
			$display("a bound handshake or frame start assertion failed");
			stop_run();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// packet front end, rx stream for each write command

	initial begin
		int n;
		word_t w;
		forever begin
			@(negedge dma_clk);
			if (o_wr_req) begin
				n = (o_wr_len + 3) / 4;
				for (int k = 0; k < n; k++) begin
					@(posedge dma_clk);
					i_rx_valid <= 1'b0;
					repeat ($random(seed) & 1) @(posedge dma_clk);
					w = $random(seed);
					exp_wr.push_back(w);
					i_rx_valid <= 1'b1;
					i_rx_data  <= w;
				end
				@(posedge dma_clk);
				i_rx_valid <= 1'b0;
				while (o_wr_req) @(negedge dma_clk);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// memory engine model

	initial begin
		int idx, n, base, done_cnt;
		logic is_rd, want;
		addr_t addr;
		len_t len;
		idx = 0;
		forever begin
			@(negedge dma_clk);
			if (o_wr_req || o_rd_req) begin
				is_rd = o_rd_req;
				addr  = is_rd ? o_rd_addr : o_wr_addr;
				len   = is_rd ? o_rd_len : o_wr_len;
				check_flag("o_rd_req", is_rd, tbl[idx].cmd.rd);
				check_addr(is_rd ? "o_rd_addr" : "o_wr_addr", addr, tbl[idx].cmd.addr);
				check_len(is_rd ? "o_rd_len" : "o_wr_len", len, tbl[idx].cmd.len);
				n    = (len + 3) / 4;
				base = addr >> 2;
				for (int k = 0; k < tbl[idx].frames; k++)
					exp_chunk.push_back(chunk_len_of(len, k));
				frames_target += tbl[idx].frames;
				idx++;
				// four-phase handshake, random ack timing
				repeat ($random(seed) & 3) @(posedge dma_clk);
				@(posedge dma_clk);
				if (is_rd) i_rd_ack <= 1'b1;
				else i_wr_ack <= 1'b1;
				do @(negedge dma_clk); while (o_wr_req || o_rd_req);
				repeat ($random(seed) & 3) @(posedge dma_clk);
				@(posedge dma_clk);
				i_rd_ack <= 1'b0;
				i_wr_ack <= 1'b0;
				done_cnt = 0;
				if (!is_rd) begin
					while (done_cnt < n) begin
						@(negedge dma_clk);
						if (i_wr_data_req) begin
							if (exp_wr.size() == 0) begin
								$display("memory pulled a word that was never received");
								stop_run();
							end
							check_word("o_wr_data", o_wr_data, exp_wr.pop_front());
							mem[(base + done_cnt) % MEM_WORDS] = o_wr_data;
							done_cnt++;
						end
						want = o_wr_data_ready && (done_cnt < n) && (($random(seed) & 3) != 0);
						@(posedge dma_clk);
						i_wr_data_req <= want;
					end
				end else begin
					while (done_cnt < n) begin
						@(negedge dma_clk);
						want = o_rd_data_ready && (($random(seed) & 3) != 0);
						@(posedge dma_clk);
						i_rd_data_valid <= want;
						if (want) begin
							i_rd_data <= mem[(base + done_cnt) % MEM_WORDS];
							exp_tx.push_back(mem[(base + done_cnt) % MEM_WORDS]);
							done_cnt++;
						end
					end
					@(posedge dma_clk);
					i_rd_data_valid <= 1'b0;
					while (frames_done < frames_target) @(negedge dma_clk);
				end
				@(posedge dma_clk);
				if (is_rd) i_rd_done <= 1'b1;
				else i_wr_done <= 1'b1;
				@(posedge dma_clk);
				i_rd_done <= 1'b0;
				i_wr_done <= 1'b0;
				cmds_done++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// mac model, throttled reads

	initial begin
		int n;
		forever begin
			@(negedge dma_clk);
			if (o_tx_start) begin
				if (exp_chunk.size() == 0) begin
					$display("frame started with no chunk expected");
					stop_run();
				end
				check_len("o_tx_len", o_tx_len, exp_chunk.pop_front());
				n = (o_tx_len + 3) / 4;
				// slow mac, the tx buffer fills past the read limit meanwhile
				repeat (`ETH_BUF_DEPTH) @(posedge dma_clk);
				for (int k = 0; k < n; k++) begin
					repeat ($random(seed) & 7) @(posedge dma_clk);
					@(posedge dma_clk);
					i_tx_data_req <= 1'b1;
					@(negedge dma_clk);
					check_word("o_tx_data", o_tx_data, exp_tx.pop_front());
					@(posedge dma_clk);
					i_tx_data_req <= 1'b0;
				end
				@(posedge dma_clk);
				i_tx_done <= 1'b1;
				@(posedge dma_clk);
				i_tx_done <= 1'b0;
				frames_done++;
			end
		end
	end

	// words pushed by the memory less words read by the mac
	always @(posedge dma_clk) begin
		tx_words <= tx_words + int'(i_rd_data_valid) - int'(i_tx_data_req);
	end

	// back-pressure toward the memory
	always @(negedge dma_clk) begin
		if (dma_rstn && tx_words > `ETH_RD_LIMIT)
			check_flag("o_rd_data_ready", o_rd_data_ready, 1'b0);
	end

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		int total;
		tbl[0] = '{cmd: '{rd: 1'b0, addr: 32'h000, len: 32'd40},  frames: 4'd0};
		tbl[1] = '{cmd: '{rd: 1'b0, addr: 32'h100, len: 32'd64},  frames: 4'd0};
		tbl[2] = '{cmd: '{rd: 1'b0, addr: 32'h200, len: 32'd150}, frames: 4'd0};
		tbl[3] = '{cmd: '{rd: 1'b0, addr: 32'h300, len: 32'd200}, frames: 4'd0};
		tbl[4] = '{cmd: '{rd: 1'b1, addr: 32'h100, len: 32'd64},  frames: 4'd1};
		tbl[5] = '{cmd: '{rd: 1'b1, addr: 32'h400, len: 32'd40},  frames: 4'd1};
		tbl[6] = '{cmd: '{rd: 1'b1, addr: 32'h200, len: 32'd150}, frames: 4'd3};
		tbl[7] = '{cmd: '{rd: 1'b1, addr: 32'h600, len: 32'd200}, frames: 4'd4};
		total = 0;
		for (int i = 0; i < N_ROWS; i++)
			total += tbl[i].cmd.len;
		limit = 40 * total + 2000;
		for (int j = 0; j < MEM_WORDS; j++)
			mem[j] = $random(seed);

		dma_rstn        <= 1'b0;
		i_cmd_valid     <= 1'b0;
		i_cmd           <= '0;
		i_rx_valid      <= 1'b0;
		i_rx_data       <= '0;
		i_wr_ack        <= 1'b0;
		i_wr_data_req   <= 1'b0;
		i_wr_done       <= 1'b0;
		i_rd_ack        <= 1'b0;
		i_rd_data_valid <= 1'b0;
		i_rd_data       <= '0;
		i_rd_done       <= 1'b0;
		i_tx_data_req   <= 1'b0;
		i_tx_done       <= 1'b0;
		repeat (5) @(posedge dma_clk);
		dma_rstn <= 1'b1;
		@(negedge dma_clk);
		check_flag("o_wr_req", o_wr_req, 1'b0);
		check_flag("o_rd_req", o_rd_req, 1'b0);
		check_flag("o_tx_start", o_tx_start, 1'b0);
		check_flag("o_wr_data_ready", o_wr_data_ready, 1'b0);
		check_flag("o_rd_data_ready", o_rd_data_ready, 1'b1);

		// rows go in back-to-back pairs so two commands sit in the queue
		for (int i = 0; i < N_ROWS; i += 2) begin
			@(posedge dma_clk);
			i_cmd_valid <= 1'b1;
			i_cmd       <= tbl[i].cmd;
			@(posedge dma_clk);
			i_cmd       <= tbl[i+1].cmd;
			@(posedge dma_clk);
			i_cmd_valid <= 1'b0;
			while (cmds_done < i + 2) @(negedge dma_clk);
		end
		while (frames_done < frames_target) @(negedge dma_clk);

		if (exp_wr.size() != 0 || exp_tx.size() != 0 || exp_chunk.size() != 0) begin
			$display("expected data left over after the last command");
			stop_run();
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hw
hw/eth_dma_pkg.sv
hw/eth_dma_fifo.sv
hw/eth_dma_rx_path.sv
hw/eth_dma_cmd_fsm.sv
hw/eth_tx_len_split.sv
hw/eth_dma_tx_seq.sv
hw/eth_dma_top.sv
tests/eth_dma_sva.sv
tests/tb_eth_dma.sv

/* Bender.yml */
package:
  name: eth_dma

sources:
  - target: rtl
    include_dirs:
      - hw
    files:
      - hw/eth_dma_pkg.sv
      - hw/eth_dma_fifo.sv
      - hw/eth_dma_rx_path.sv
      - hw/eth_dma_cmd_fsm.sv
      - hw/eth_tx_len_split.sv
      - hw/eth_dma_tx_seq.sv
      - hw/eth_dma_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/eth_dma_sva.sv
      - tests/tb_eth_dma.sv
